//--- src.f
hdl/core_pkg.sv
hdl/mem_bus_pkg.sv
hdl/pipe_reg.sv
hdl/memory_stage.sv
hdl/data_memory.sv
hdl/dmem_wait_cfg.sv
hdl/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - hdl/core_pkg.sv
  - hdl/mem_bus_pkg.sv
  - hdl/pipe_reg.sv
  - hdl/memory_stage.sv
  - hdl/data_memory.sv
  - hdl/dmem_wait_cfg.sv
  - hdl/mem_subsystem_top.sv
  - target: simulation
    files:
      - dv/tb_mem_subsystem.sv

//--- dv/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
    import core_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int MEM_BYTES  = DMEM_WORDS * 4;
    localparam int WAIT_LIMIT = 200;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    ex_mem_t   in_data;
    logic      flush;
    logic      cfg_we;
    wait_cfg_t cfg_wdata;
    logic      out_valid;
    mem_wb_t   out_data;
    logic      stall;

    logic [7:0] shadow [MEM_BYTES]; // expected memory contents in little endian order
    wait_cfg_t  cur_cfg;            // waits the memory currently runs with
    inst_id_t   next_id;
    int         seed;
    int         errors;
    int         checks;

    mem_subsystem_top i_mem_subsystem_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .flush    (flush),
        .cfg_we   (cfg_we),
        .cfg_wdata(cfg_wdata),
        .out_valid(out_valid),
        .out_data (out_data),
        .stall    (stall)
    );

    always #5 clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic ex_mem_t make_instr(input mem_op_t op, input mem_size_t size,
                                           input logic [31:0] addr, input logic [31:0] data);
        ex_mem_t r;
        r               = '0;
        r.pc            = 32'h0000_1000 + {22'd0, next_id, 2'b00};
        r.inst          = $random(seed);
        r.inst_id       = next_id;
        r.ctrl.mem_op   = op;
        r.ctrl.mem_size = size;
        r.alu_out       = addr;
        r.rs2_data      = data;
        r.csr_rdata     = $random(seed);
        next_id = (next_id == 8'hfe) ? 8'h00 : next_id + 8'h01; // 8'hff is never issued
        return r;
    endfunction

    function automatic logic [31:0] rand_addr();
        return $random(seed) & 32'h0000_03fc; // word aligned inside the RAM
    endfunction

    task automatic shadow_store(input mem_size_t size, input logic [31:0] addr,
                                input logic [31:0] data);
        int a;
        a = int'(addr[9:0]);
        shadow[a] = data[7:0];
        if (size != SIZE_B) begin
            shadow[a + 1] = data[15:8];
        end
        if (size == SIZE_W) begin
            shadow[a + 2] = data[23:16];
            shadow[a + 3] = data[31:24];
        end
    endtask

    function automatic logic [31:0] load_expect(input mem_op_t op, input mem_size_t size,
                                                input logic [31:0] addr);
        int          base;
        logic [31:0] w;
        base = int'({addr[9:2], 2'b00});
        w    = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
        w    = w >> (8 * addr[1:0]); // addressed lane down to bit 0
        case (size)
            SIZE_B:  return (op == MEM_LOAD_S) ? {{24{w[7]}}, w[7:0]} : {24'd0, w[7:0]};
            SIZE_H:  return (op == MEM_LOAD_S) ? {{16{w[15]}}, w[15:0]} : {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    // drive one instruction, follow stall and collect the single result
    task automatic run_instr(input ex_mem_t instr, output mem_wb_t result);
        int busy;
        int waited;
        int exp_busy;
        busy   = 0;
        waited = 0;
        case (instr.ctrl.mem_op)
            MEM_NONE:  exp_busy = 0;
            MEM_STORE: exp_busy = 2 + cur_cfg.ready_wait;
            default:   exp_busy = 3 + cur_cfg.ready_wait + cur_cfg.resp_wait;
        endcase
        in_valid = 1'b1;
        in_data  = instr;
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = '0;
        while (stall && busy < WAIT_LIMIT) begin
            check("out_valid while stalled", out_valid, 1'b0);
            busy++;
            @(negedge clk);
        end
        if (stall) begin
            errors++;
            $display("timeout at t=%0t: stall stayed high for %0d cycles", $time, WAIT_LIMIT);
        end
        check("stall cycles", busy, exp_busy);
        while (!out_valid && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!out_valid) begin
            errors++;
            $display("timeout at t=%0t: out_valid never rose", $time);
        end
        check("out_valid latency", waited, 1);
        result = out_data;
        check("out_data.pc", result.pc, instr.pc);
        check("out_data.inst", result.inst, instr.inst);
        check("out_data.inst_id", result.inst_id, instr.inst_id);
        check("out_data.ctrl", result.ctrl, instr.ctrl);
        check("out_data.alu_out", result.alu_out, instr.alu_out);
        check("out_data.csr_rdata", result.csr_rdata, instr.csr_rdata);
        @(negedge clk);
        check("out_valid repeat", out_valid, 1'b0); // one result per instruction
    endtask

    task automatic do_store(input mem_size_t size, input logic [31:0] addr,
                            input logic [31:0] data);
        mem_wb_t res;
        run_instr(make_instr(MEM_STORE, size, addr, data), res);
        shadow_store(size, addr, data);
    endtask

    task automatic do_load(input mem_op_t op, input mem_size_t size, input logic [31:0] addr);
        mem_wb_t     res;
        logic [31:0] expected;
        expected = load_expect(op, size, addr);
        run_instr(make_instr(op, size, addr, 32'd0), res);
        check("out_data.mem_rdata", res.mem_rdata, expected);
    endtask

    task automatic set_waits(input logic [3:0] ready_wait, input logic [3:0] resp_wait);
        cfg_we               = 1'b1;
        cfg_wdata.ready_wait = ready_wait;
        cfg_wdata.resp_wait  = resp_wait;
        @(negedge clk);
        cfg_we  = 1'b0;
        cur_cfg = cfg_wdata;
    endtask

    task automatic test_passthrough();
        mem_wb_t res;
        for (int i = 0; i < 4; i++) begin
            run_instr(make_instr(MEM_NONE, SIZE_W, $random(seed), $random(seed)), res);
        end
    endtask

    task automatic test_word_rw();
        logic [31:0] addr;
        for (int i = 0; i < 20; i++) begin
            addr = rand_addr();
            do_store(SIZE_W, addr, $random(seed));
            do_load(MEM_LOAD_S, SIZE_W, addr);
        end
    endtask

    task automatic test_sub_word();
        logic [31:0] addr;
        addr = rand_addr();
        do_store(SIZE_W, addr, $random(seed));
        do_store(SIZE_B, addr + 1, 32'h0000_009c);
        do_store(SIZE_H, addr + 2, 32'h1234_80f3); // upper half must not land
        for (int lane = 0; lane < 4; lane++) begin
            do_load(MEM_LOAD_S, SIZE_B, addr + lane);
            do_load(MEM_LOAD_U, SIZE_B, addr + lane);
        end
        do_load(MEM_LOAD_S, SIZE_H, addr);
        do_load(MEM_LOAD_U, SIZE_H, addr);
        do_load(MEM_LOAD_S, SIZE_H, addr + 2);
        do_load(MEM_LOAD_U, SIZE_H, addr + 2);
        do_load(MEM_LOAD_S, SIZE_W, addr);
    endtask

    task automatic test_wait_states();
        logic [31:0] addr;
        logic [3:0]  rw [4];
        logic [3:0]  sw [4];
        rw = '{4'd3, 4'd1, 4'd0, 4'd15};
        sw = '{4'd5, 4'd0, 4'd7, 4'd15};
        for (int i = 0; i < 4; i++) begin
            set_waits(rw[i], sw[i]);
            addr = rand_addr();
            do_store(SIZE_W, addr, $random(seed));
            do_load(MEM_LOAD_U, SIZE_W, addr);
            do_load(MEM_LOAD_S, SIZE_B, addr + 3);
            do_load(MEM_LOAD_U, SIZE_H, addr + 2);
        end
        set_waits(4'd0, 4'd0);
    endtask

    task automatic test_held_store();
        logic [31:0] addr;
        set_waits(4'd4, 4'd2); // store sits under stall for several cycles
        addr = rand_addr();
        do_store(SIZE_W, addr, $random(seed));
        do_store(SIZE_B, addr + 1, $random(seed));
        do_load(MEM_LOAD_U, SIZE_W, addr);
        do_load(MEM_LOAD_U, SIZE_B, addr);
        do_load(MEM_LOAD_U, SIZE_B, addr + 2);
        set_waits(4'd0, 4'd0);
    endtask

    task automatic test_flush();
        logic [31:0] addr;
        logic [31:0] old_word;
        set_waits(4'd5, 4'd1);
        addr = rand_addr();
        do_store(SIZE_W, addr, $random(seed));
        old_word = load_expect(MEM_LOAD_U, SIZE_W, addr);
        in_valid = 1'b1;
        in_data  = make_instr(MEM_NONE, SIZE_W, addr, 32'd0); // parks in the output register
        @(negedge clk);
        in_data  = make_instr(MEM_STORE, SIZE_W, addr, ~old_word);
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = '0;
        check("stall before flush", stall, 1'b1);
        check("out_valid before flush", out_valid, 1'b1);
        @(negedge clk);
        flush = 1'b1; // stage is waiting for ready here
        @(negedge clk);
        flush = 1'b0;
        check("out_valid after flush", out_valid, 1'b0);
        check("stall after flush", stall, 1'b0);
        @(negedge clk);
        check("out_valid after flush", out_valid, 1'b0);
        do_load(MEM_LOAD_U, SIZE_W, addr); // shadow still holds the old word
        set_waits(4'd0, 4'd0);
    endtask

    initial begin
        seed      = 32'h33d9_b207;
        errors    = 0;
        checks    = 0;
        next_id   = 8'h00;
        cur_cfg   = '0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        flush     = 1'b0;
        cfg_we    = 1'b0;
        cfg_wdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("out_valid after reset", out_valid, 1'b0);
        check("stall after reset", stall, 1'b0);

        test_passthrough();
        test_word_rw();
        test_sub_word();
        test_wait_states();
        test_held_store();
        test_flush();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
    import core_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  ex_mem_t   in_data,
    input  logic      flush,
    input  logic      cfg_we,
    input  wait_cfg_t cfg_wdata,
    output logic      out_valid,
    output mem_wb_t   out_data,
    output logic      stall
);

    logic      ex_valid;
    ex_mem_t   ex_data;
    logic      wb_valid;
    mem_wb_t   wb_data;
    dreq_t     dreq;
    dresp_t    dresp;
    wait_cfg_t cfg;

    // execute -> memory register
    pipe_reg #(
        .payload_t(ex_mem_t)
    ) i_ex_mem_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .in_valid (in_valid),
        .in_data  (in_data),
        .out_valid(ex_valid),
        .out_data (ex_data)
    );

    memory_stage i_memory_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_valid(ex_valid),
        .in_data (ex_data),
        .flush   (flush),
        .wb_valid(wb_valid),
        .wb_data (wb_data),
        .stall   (stall),
        .dreq    (dreq),
        .dresp   (dresp)
    );

    // memory -> writeback register
    pipe_reg #(
        .payload_t(mem_wb_t)
    ) i_mem_wb_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .in_valid (wb_valid),
        .in_data  (wb_data),
        .out_valid(out_valid),
        .out_data (out_data)
    );

    data_memory i_data_memory (
        .clk  (clk),
        .rst_n(rst_n),
        .cfg  (cfg),
        .dreq (dreq),
        .dresp(dresp)
    );

    dmem_wait_cfg i_dmem_wait_cfg (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_we   (cfg_we),
        .cfg_wdata(cfg_wdata),
        .cfg      (cfg)
    );

endmodule

//--- hdl/dmem_wait_cfg.sv
`timescale 1ns/1ps

module dmem_wait_cfg
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cfg_we,
    input  wait_cfg_t cfg_wdata,
    output wait_cfg_t cfg
);

    // zero waits out of reset, ready and response as fast as possible
    // a write lands at once, even mid-access; the memory only picks
    // the value up when it starts its next countdown
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (cfg_we) begin
            cfg <= cfg_wdata;
        end
    end

endmodule

//--- hdl/data_memory.sv
`timescale 1ns/1ps

module data_memory
    import core_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  wait_cfg_t cfg,
    input  dreq_t     dreq,
    output dresp_t    dresp
);

    logic [31:0] mem [DMEM_WORDS];

    logic                          seen;         // accept countdown running
    logic [3:0]                    ready_cnt;
    logic                          resp_pending;
    logic [3:0]                    resp_cnt;
    logic [31:0]                   resp_rdata;
    logic                          accept;
    logic [$clog2(DMEM_WORDS)-1:0] widx;
    logic [4:0]                    lane_sh;
    logic [3:0]                    lane_en;
    logic [31:0]                   wdata_sh;

    assign widx     = dreq.addr[$clog2(DMEM_WORDS)+1:2];
    assign lane_sh  = {dreq.addr[1:0], 3'b000};
    assign wdata_sh = dreq.wdata << lane_sh;

    always_comb begin
        case (dreq.size)
            SIZE_B:  lane_en = 4'b0001 << dreq.addr[1:0];
            SIZE_H:  lane_en = 4'b0011 << {dreq.addr[1], 1'b0};
            default: lane_en = 4'b1111;
        endcase
    end

    always_comb begin
        dresp.ready = dreq.valid && (seen ? ready_cnt == 4'd0 : cfg.ready_wait == 4'd0);
        dresp.valid = resp_pending && resp_cnt == 4'd0;
        dresp.rdata = resp_rdata;
    end

    assign accept = dreq.valid && dresp.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen      <= 1'b0;
            ready_cnt <= 4'd0;
        end else if (accept || !dreq.valid) begin
            seen <= 1'b0; // also forgets an aborted request
        end else if (!seen) begin
            seen      <= 1'b1;
            ready_cnt <= cfg.ready_wait - 4'd1; // cfg sampled here only
        end else if (ready_cnt != 4'd0) begin
            ready_cnt <= ready_cnt - 4'd1;
        end
    end

    // response lands resp_wait+1 cycles after acceptance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_pending <= 1'b0;
            resp_cnt     <= 4'd0;
        end else if (accept && !dreq.wen) begin
            resp_pending <= 1'b1;
            resp_cnt     <= cfg.resp_wait;
        end else if (dresp.valid) begin
            resp_pending <= 1'b0;
        end else if (resp_pending) begin
            resp_cnt <= resp_cnt - 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !dreq.wen) begin
            resp_rdata <= mem[widx] >> lane_sh;
        end
        if (accept && dreq.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[widx][8*b +: 8] <= wdata_sh[8*b +: 8];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> !resp_pending)
        else $error("data_memory: request accepted with a response pending");

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
    import core_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  ex_mem_t in_data,
    input  logic    flush,
    output logic    wb_valid,
    output mem_wb_t wb_data,
    output logic    stall,
    output dreq_t   dreq,
    input  dresp_t  dresp
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_VALID
    } state_t;

    state_t      state;
    inst_id_t    done_id;  // last instruction whose access finished
    inst_id_t    issue_id; // owner of the access in flight
    logic [31:0] load_raw;
    logic [31:0] load_ext;
    logic        is_mem;
    logic        is_store;
    logic        is_load;
    logic        sign_ext;
    logic        may_start;

    assign is_mem    = in_data.ctrl.mem_op != MEM_NONE;
    assign is_store  = in_data.ctrl.mem_op == MEM_STORE;
    assign is_load   = is_mem && !is_store;
    assign sign_ext  = in_data.ctrl.mem_op == MEM_LOAD_S;
    assign may_start = done_id != in_data.inst_id; // id guard

    // drops the cycle after completion when the guard holds the id
    assign stall = in_valid && is_mem && (state != IDLE || may_start);

    always_comb begin
        dreq.valid = state == WAIT_READY && !flush;
        dreq.wen   = is_store;
        dreq.addr  = in_data.alu_out;
        dreq.wdata = in_data.rs2_data;
        dreq.size  = in_data.ctrl.mem_size;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            done_id <= INST_ID_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (in_valid && is_mem && may_start && !flush) begin
                        state <= WAIT_READY;
                    end
                end
                WAIT_READY: begin
                    if (flush || !in_valid) begin
                        state <= IDLE; // dropped before acceptance
                    end else if (dresp.ready) begin
                        if (is_store) begin
                            state   <= IDLE; // store done at acceptance
                            done_id <= issue_id;
                        end else begin
                            state <= WAIT_VALID;
                        end
                    end
                end
                WAIT_VALID: begin
                    // accepted loads always drain even after a flush
                    if (dresp.valid) begin
                        state   <= IDLE;
                        done_id <= issue_id;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            issue_id <= in_data.inst_id;
        end
        if (state == WAIT_VALID && dresp.valid) begin
            load_raw <= dresp.rdata;
        end
    end

    always_comb begin
        case (in_data.ctrl.mem_size)
            SIZE_B:  load_ext = {{24{sign_ext & load_raw[7]}}, load_raw[7:0]};
            SIZE_H:  load_ext = {{16{sign_ext & load_raw[15]}}, load_raw[15:0]};
            default: load_ext = load_raw; // word
        endcase
    end

    assign wb_valid = in_valid && !flush;

    always_comb begin
        wb_data.pc        = in_data.pc;
        wb_data.inst      = in_data.inst;
        wb_data.inst_id   = in_data.inst_id;
        wb_data.ctrl      = in_data.ctrl;
        wb_data.alu_out   = in_data.alu_out;
        wb_data.mem_rdata = is_load ? load_ext : 32'd0;
        wb_data.csr_rdata = in_data.csr_rdata; // csr data untouched
    end

    // a request only goes out for a held memory instruction the guard has not seen
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dreq.valid) |-> in_valid && is_mem && may_start)
        else $error("memory_stage: request raised with no access owed");

    assert property (@(posedge clk) disable iff (!rst_n)
        dresp.valid |-> state == WAIT_VALID)
        else $error("memory_stage: response with no load waiting");

endmodule

//--- hdl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // flush wins over stall, the slot is emptied either way
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data; // payload only, valid qualifies it
        end
    end

    // a held entry must not change under the consumer
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && stall |=> $stable(out_data))
        else $error("pipe_reg: payload changed while held");

endmodule

//--- hdl/mem_bus_pkg.sv
package mem_bus_pkg;

    import core_pkg::*;

    localparam int DMEM_WORDS = 256;

    typedef struct packed {
        logic        valid; // level, held until ready
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata; // unshifted, lane 0
        mem_size_t   size;
    } dreq_t;

    typedef struct packed {
        logic        ready; // acceptance strobe
        logic        valid; // single-cycle read response
        logic [31:0] rdata; // addressed lane moved down to bit 0
    } dresp_t;

    typedef struct packed {
        logic [3:0] ready_wait;
        logic [3:0] resp_wait;
    } wait_cfg_t;

endpackage

//--- hdl/core_pkg.sv
package core_pkg;

    // memory operation carried in the control bundle
    typedef enum logic [1:0] {
        MEM_NONE   = 2'd0,
        MEM_STORE  = 2'd1,
        MEM_LOAD_S = 2'd2, // lb, lh, lw
        MEM_LOAD_U = 2'd3  // lbu, lhu
    } mem_op_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_t;

    typedef logic [7:0] inst_id_t;

    localparam inst_id_t INST_ID_NONE = 8'hff; // never issued

    typedef struct packed {
        mem_op_t   mem_op;
        mem_size_t mem_size;
    } ctrl_t;

    // execute -> memory
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        inst_id_t    inst_id;
        ctrl_t       ctrl;
        logic [31:0] alu_out;   // effective address
        logic [31:0] rs2_data;  // store data
        logic [31:0] csr_rdata;
    } ex_mem_t;

    // memory -> writeback
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        inst_id_t    inst_id;
        ctrl_t       ctrl;
        logic [31:0] alu_out;
        logic [31:0] mem_rdata; // already extended
        logic [31:0] csr_rdata;
    } mem_wb_t;

endpackage
